// ==== src/mesh_cfg.svh ====
/*
  grid and flit configuration shared by the RTL and the testbench
  COORD_W must hold MESH_X-1 and MESH_Y-1, and RESET_DEPTH must be at least 1
*/
`ifndef MESH_CFG_SVH
`define MESH_CFG_SVH

// grid size in nodes
`define MESH_X 2
`define MESH_Y 2

// flit field widths
`define COORD_W 1
`define DATA_W 16

// clock edges between reset release at the pin and release at every node
`define RESET_DEPTH 3

`endif

// ==== src/mesh_pkg.sv ====
/*
  types shared by the mesh RTL
  a packet is one flit with no header or tail beat
*/
`default_nettype none

`include "mesh_cfg.svh"

package mesh_pkg;

  localparam int unsigned NUM_NODES = `MESH_X * `MESH_Y;
  localparam int unsigned NUM_PORTS = 5;

  // router port index, local host port first
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  typedef logic [`COORD_W-1:0] coord_t;

  // 20 bits with the default widths
  typedef struct packed {
    coord_t             dest_x;
    coord_t             dest_y;
    coord_t             src_x;
    coord_t             src_y;
    logic [`DATA_W-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire

// ==== src/reset_pipe.sv ====
/*
  reset pipeline: asserts at once, releases RESET_DEPTH rising edges after rst_n_i rises
  rst_n_o is meant to drive the asynchronous reset of all mesh logic
*/
`default_nettype none

`include "mesh_cfg.svh"

module reset_pipe (
  input  wire  clk_i,
  input  wire  rst_n_i,
  output logic rst_n_o
);

  logic [`RESET_DEPTH-1:0] stage_q;

  // ones shift in from bit 0 once the pin is released
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      stage_q <= '0;
    else
      stage_q <= (stage_q << 1) | `RESET_DEPTH'(1);
  end

  assign rst_n_o = stage_q[`RESET_DEPTH-1];

endmodule

`default_nettype wire

// ==== src/rr_arbiter.sv ====
/*
  round-robin arbiter over the five router input ports
  grant_o is combinational; the pointer moves only on edges where used_i is high
*/
`default_nettype none

module rr_arbiter (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire  [mesh_pkg::NUM_PORTS-1:0] req_i,
  input  wire                            used_i,
  output logic [mesh_pkg::NUM_PORTS-1:0] grant_o
);

  // input with the highest priority for the next decision
  mesh_pkg::dir_e ptr_q;
  mesh_pkg::dir_e ptr_d;

  always_comb
  begin
    int unsigned idx;
    logic        found;
    grant_o = '0;
    ptr_d   = ptr_q;
    found   = 1'b0;
    // walk once around the ring starting at the pointer
    for (int unsigned i = 0; i < mesh_pkg::NUM_PORTS; i++)
    begin
      idx = (ptr_q + i) % mesh_pkg::NUM_PORTS;
      if (!found && req_i[idx])
      begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        ptr_d        = mesh_pkg::dir_e'((idx + 1) % mesh_pkg::NUM_PORTS);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ptr_q <= mesh_pkg::P;
    else if (used_i)
      ptr_q <= ptr_d;
  end

  // at most one winner and only among live requests
  a_grant_legal: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_o) && ((grant_o & ~req_i) == '0)
  );

endmodule

`default_nettype wire

// ==== src/mesh_router.sv ====
/*
  five-port mesh router with one-entry input buffers and XY dimension-order routing
  in_ready_o is the buffer-empty flag, so one link carries at most one flit every two cycles
  destinations must lie inside the grid, otherwise a flit would wait on a closed edge forever
*/
`default_nettype none

module mesh_router (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire mesh_pkg::coord_t          my_x_i,
  input  wire mesh_pkg::coord_t          my_y_i,
  input  wire mesh_pkg::flit_t           in_flit_i  [mesh_pkg::NUM_PORTS],
  input  wire  [mesh_pkg::NUM_PORTS-1:0] in_valid_i,
  output logic [mesh_pkg::NUM_PORTS-1:0] in_ready_o,
  output mesh_pkg::flit_t                out_flit_o [mesh_pkg::NUM_PORTS],
  output logic [mesh_pkg::NUM_PORTS-1:0] out_valid_o,
  input  wire  [mesh_pkg::NUM_PORTS-1:0] out_ready_i
);

  localparam int unsigned NP = mesh_pkg::NUM_PORTS;

  mesh_pkg::flit_t buf_q      [NP];
  logic [NP-1:0]   buf_full_q;
  logic [NP-1:0]   buf_we;
  logic [NP-1:0]   buf_deq;
  mesh_pkg::dir_e  route      [NP];
  // req_by_out[o][i] is set when input i wants output o
  logic [NP-1:0]   req_by_out [NP];
  logic [NP-1:0]   grant      [NP];

  assign in_ready_o = ~buf_full_q;
  assign buf_we     = in_valid_i & ~buf_full_q;

  // X first, then Y, then the local port
  always_comb
  begin
    for (int i = 0; i < NP; i++)
    begin
      if (buf_q[i].dest_x > my_x_i)
        route[i] = mesh_pkg::E;
      else if (buf_q[i].dest_x < my_x_i)
        route[i] = mesh_pkg::W;
      else if (buf_q[i].dest_y > my_y_i)
        route[i] = mesh_pkg::N;
      else if (buf_q[i].dest_y < my_y_i)
        route[i] = mesh_pkg::S;
      else
        route[i] = mesh_pkg::P;
    end
  end

  always_comb
  begin
    for (int o = 0; o < NP; o++)
    begin
      for (int i = 0; i < NP; i++)
      begin
        req_by_out[o][i] = buf_full_q[i] && (route[i] == mesh_pkg::dir_e'(o));
      end
    end
  end

  // one arbiter per output port
  for (genvar o = 0; o < NP; o++)
  begin : g_out
    rr_arbiter u_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (req_by_out[o]),
      .used_i  (out_valid_o[o] && out_ready_i[o]),
      .grant_o (grant[o])
    );
  end

  // output mux, and the buffers that empty this cycle
  always_comb
  begin
    buf_deq = '0;
    for (int o = 0; o < NP; o++)
    begin
      out_valid_o[o] = |grant[o];
      out_flit_o[o]  = '0;
      for (int i = 0; i < NP; i++)
      begin
        if (grant[o][i])
        begin
          out_flit_o[o] = buf_q[i];
          buf_deq[i]    = out_ready_i[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      buf_full_q <= '0;
    else
      buf_full_q <= (buf_full_q & ~buf_deq) | buf_we;
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < NP; i++)
    begin
      if (buf_we[i])
        buf_q[i] <= in_flit_i[i];
    end
  end

  for (genvar i = 0; i < NP; i++)
  begin : g_chk
    // a full buffer keeps its flit untouched until it is forwarded
    a_no_overwrite: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (buf_full_q[i] && !buf_deq[i]) |=> (buf_full_q[i] && $stable(buf_q[i]))
    );
  end

endmodule

`default_nettype wire

// ==== src/endpoint_fsm.sv ====
/*
  host endpoint: four-phase req/ack toward the host, valid/ready toward the router P port
  host signals are taken as synchronous to clk_i; inject fields must hold while req is high
*/
`default_nettype none

`include "mesh_cfg.svh"

module endpoint_fsm (
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wire mesh_pkg::coord_t my_x_i,
  input  wire mesh_pkg::coord_t my_y_i,
  input  wire                   inj_req_i,
  input  wire mesh_pkg::coord_t inj_dest_x_i,
  input  wire mesh_pkg::coord_t inj_dest_y_i,
  input  wire [`DATA_W-1:0]     inj_data_i,
  output logic                  inj_ack_o,
  output logic                  ej_req_o,
  output mesh_pkg::coord_t      ej_src_x_o,
  output mesh_pkg::coord_t      ej_src_y_o,
  output logic [`DATA_W-1:0]    ej_data_o,
  input  wire                   ej_ack_i,
  output mesh_pkg::flit_t       to_rtr_flit_o,
  output logic                  to_rtr_valid_o,
  input  wire                   to_rtr_ready_i,
  input  wire mesh_pkg::flit_t  from_rtr_flit_i,
  input  wire                   from_rtr_valid_i,
  output logic                  from_rtr_ready_o
);

  typedef enum logic [1:0] {INJ_IDLE, INJ_SEND, INJ_WAIT_LOW} inj_state_e;
  typedef enum logic [1:0] {EJ_EMPTY, EJ_HOLD, EJ_WAIT_LOW} ej_state_e;

  inj_state_e      inj_state_q;
  ej_state_e       ej_state_q;
  mesh_pkg::flit_t inj_flit_q;
  mesh_pkg::flit_t ej_flit_q;

  // inject side
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      inj_state_q <= INJ_IDLE;
    else
    begin
      case (inj_state_q)
        INJ_IDLE:
          if (inj_req_i)
            inj_state_q <= INJ_SEND;
        // ack goes up on the edge that loads the P buffer
        INJ_SEND:
          if (to_rtr_ready_i)
            inj_state_q <= INJ_WAIT_LOW;
        INJ_WAIT_LOW:
          if (!inj_req_i)
            inj_state_q <= INJ_IDLE;
        default:
          inj_state_q <= INJ_IDLE;
      endcase
    end
  end

  // stamp the source coordinates when the request is first seen
  always_ff @(posedge clk_i)
  begin
    if (inj_state_q == INJ_IDLE && inj_req_i)
    begin
      inj_flit_q.dest_x  <= inj_dest_x_i;
      inj_flit_q.dest_y  <= inj_dest_y_i;
      inj_flit_q.src_x   <= my_x_i;
      inj_flit_q.src_y   <= my_y_i;
      inj_flit_q.payload <= inj_data_i;
    end
  end

  assign to_rtr_flit_o  = inj_flit_q;
  assign to_rtr_valid_o = (inj_state_q == INJ_SEND);
  assign inj_ack_o      = (inj_state_q == INJ_WAIT_LOW);

  // eject side
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ej_state_q <= EJ_EMPTY;
    else
    begin
      case (ej_state_q)
        EJ_EMPTY:
          if (from_rtr_valid_i)
            ej_state_q <= EJ_HOLD;
        EJ_HOLD:
          if (ej_ack_i)
            ej_state_q <= EJ_WAIT_LOW;
        // no new flit until the host has dropped ack
        EJ_WAIT_LOW:
          if (!ej_ack_i)
            ej_state_q <= EJ_EMPTY;
        default:
          ej_state_q <= EJ_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (from_rtr_valid_i && from_rtr_ready_o)
      ej_flit_q <= from_rtr_flit_i;
  end

  assign from_rtr_ready_o = (ej_state_q == EJ_EMPTY);
  assign ej_req_o         = (ej_state_q == EJ_HOLD);
  assign ej_src_x_o       = ej_flit_q.src_x;
  assign ej_src_y_o       = ej_flit_q.src_y;
  assign ej_data_o        = ej_flit_q.payload;

  a_ej_req_fall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $fell(ej_req_o) |-> $past(ej_ack_i)
  );

  // routing must only hand this node flits addressed to it
  a_ej_dest: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ej_req_o |-> (ej_flit_q.dest_x == my_x_i && ej_flit_q.dest_y == my_y_i)
  );

endmodule

`default_nettype wire

// ==== src/mesh_array.sv ====
/*
  MESH_X by MESH_Y mesh of routers, one host endpoint per node, closed edges
  node index is y * MESH_X + x; N points toward larger y
*/
`default_nettype none

`include "mesh_cfg.svh"

module mesh_array (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire  [mesh_pkg::NUM_NODES-1:0] inj_req_i,
  input  wire mesh_pkg::coord_t          inj_dest_x_i [mesh_pkg::NUM_NODES],
  input  wire mesh_pkg::coord_t          inj_dest_y_i [mesh_pkg::NUM_NODES],
  input  wire  [`DATA_W-1:0]             inj_data_i   [mesh_pkg::NUM_NODES],
  output wire  [mesh_pkg::NUM_NODES-1:0] inj_ack_o,
  output wire  [mesh_pkg::NUM_NODES-1:0] ej_req_o,
  output wire mesh_pkg::coord_t          ej_src_x_o   [mesh_pkg::NUM_NODES],
  output wire mesh_pkg::coord_t          ej_src_y_o   [mesh_pkg::NUM_NODES],
  output wire  [`DATA_W-1:0]             ej_data_o    [mesh_pkg::NUM_NODES],
  input  wire  [mesh_pkg::NUM_NODES-1:0] ej_ack_i
);

  localparam int unsigned NN = mesh_pkg::NUM_NODES;
  localparam int unsigned NP = mesh_pkg::NUM_PORTS;

  wire                  rst_n_sync;
  // router-side view of every link, indexed by node then port
  wire mesh_pkg::flit_t rin_flit   [NN][NP];
  wire [NP-1:0]         rin_valid  [NN];
  wire [NP-1:0]         rin_ready  [NN];
  wire mesh_pkg::flit_t rout_flit  [NN][NP];
  wire [NP-1:0]         rout_valid [NN];
  wire [NP-1:0]         rout_ready [NN];

  reset_pipe u_reset_pipe (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rst_n_o (rst_n_sync)
  );

  for (genvar y = 0; y < `MESH_Y; y++)
  begin : g_row
    for (genvar x = 0; x < `MESH_X; x++)
    begin : g_col
      localparam int unsigned ND = y * `MESH_X + x;

      mesh_router u_router (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_sync),
        .my_x_i      (mesh_pkg::coord_t'(x)),
        .my_y_i      (mesh_pkg::coord_t'(y)),
        .in_flit_i   (rin_flit[ND]),
        .in_valid_i  (rin_valid[ND]),
        .in_ready_o  (rin_ready[ND]),
        .out_flit_o  (rout_flit[ND]),
        .out_valid_o (rout_valid[ND]),
        .out_ready_i (rout_ready[ND])
      );

      endpoint_fsm u_endpoint (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_sync),
        .my_x_i           (mesh_pkg::coord_t'(x)),
        .my_y_i           (mesh_pkg::coord_t'(y)),
        .inj_req_i        (inj_req_i[ND]),
        .inj_dest_x_i     (inj_dest_x_i[ND]),
        .inj_dest_y_i     (inj_dest_y_i[ND]),
        .inj_data_i       (inj_data_i[ND]),
        .inj_ack_o        (inj_ack_o[ND]),
        .ej_req_o         (ej_req_o[ND]),
        .ej_src_x_o       (ej_src_x_o[ND]),
        .ej_src_y_o       (ej_src_y_o[ND]),
        .ej_data_o        (ej_data_o[ND]),
        .ej_ack_i         (ej_ack_i[ND]),
        .to_rtr_flit_o    (rin_flit[ND][mesh_pkg::P]),
        .to_rtr_valid_o   (rin_valid[ND][mesh_pkg::P]),
        .to_rtr_ready_i   (rin_ready[ND][mesh_pkg::P]),
        .from_rtr_flit_i  (rout_flit[ND][mesh_pkg::P]),
        .from_rtr_valid_i (rout_valid[ND][mesh_pkg::P]),
        .from_rtr_ready_o (rout_ready[ND][mesh_pkg::P])
      );

      // each node drives its own inputs and output readies, edges are tied off
      if (x > 0)
      begin : g_w
        assign rin_flit[ND][mesh_pkg::W]   = rout_flit[ND-1][mesh_pkg::E];
        assign rin_valid[ND][mesh_pkg::W]  = rout_valid[ND-1][mesh_pkg::E];
        assign rout_ready[ND][mesh_pkg::W] = rin_ready[ND-1][mesh_pkg::E];
      end
      else
      begin : g_w_edge
        assign rin_flit[ND][mesh_pkg::W]   = '0;
        assign rin_valid[ND][mesh_pkg::W]  = 1'b0;
        assign rout_ready[ND][mesh_pkg::W] = 1'b0;
      end

      if (x < `MESH_X - 1)
      begin : g_e
        assign rin_flit[ND][mesh_pkg::E]   = rout_flit[ND+1][mesh_pkg::W];
        assign rin_valid[ND][mesh_pkg::E]  = rout_valid[ND+1][mesh_pkg::W];
        assign rout_ready[ND][mesh_pkg::E] = rin_ready[ND+1][mesh_pkg::W];
      end
      else
      begin : g_e_edge
        assign rin_flit[ND][mesh_pkg::E]   = '0;
        assign rin_valid[ND][mesh_pkg::E]  = 1'b0;
        assign rout_ready[ND][mesh_pkg::E] = 1'b0;
      end

      if (y > 0)
      begin : g_s
        assign rin_flit[ND][mesh_pkg::S]   = rout_flit[ND-`MESH_X][mesh_pkg::N];
        assign rin_valid[ND][mesh_pkg::S]  = rout_valid[ND-`MESH_X][mesh_pkg::N];
        assign rout_ready[ND][mesh_pkg::S] = rin_ready[ND-`MESH_X][mesh_pkg::N];
      end
      else
      begin : g_s_edge
        assign rin_flit[ND][mesh_pkg::S]   = '0;
        assign rin_valid[ND][mesh_pkg::S]  = 1'b0;
        assign rout_ready[ND][mesh_pkg::S] = 1'b0;
      end

      if (y < `MESH_Y - 1)
      begin : g_n
        assign rin_flit[ND][mesh_pkg::N]   = rout_flit[ND+`MESH_X][mesh_pkg::S];
        assign rin_valid[ND][mesh_pkg::N]  = rout_valid[ND+`MESH_X][mesh_pkg::S];
        assign rout_ready[ND][mesh_pkg::N] = rin_ready[ND+`MESH_X][mesh_pkg::S];
      end
      else
      begin : g_n_edge
        assign rin_flit[ND][mesh_pkg::N]   = '0;
        assign rin_valid[ND][mesh_pkg::N]  = 1'b0;
        assign rout_ready[ND][mesh_pkg::N] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
/*
  testbench clock and power-on reset, 100 ns period
  reset is held for five rising edges and released 10 ns after the last one
*/
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 5;

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/mesh_tb.sv ====
/*
  packets, expected eject nodes and ack delays come from tests/mesh_stimulus.txt
  lines with the same name form one test; its packets are sent together, in file order per node
  host signals change 10 ns after the rising edge and are sampled at the same point
*/
`default_nettype none

`include "mesh_cfg.svh"

module mesh_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NN = mesh_pkg::NUM_NODES;

  wire                   clk;
  wire                   rst_n;
  logic [NN-1:0]         inj_req;
  mesh_pkg::coord_t      inj_dest_x [NN];
  mesh_pkg::coord_t      inj_dest_y [NN];
  logic [`DATA_W-1:0]    inj_data   [NN];
  wire  [NN-1:0]         inj_ack;
  wire  [NN-1:0]         ej_req;
  wire mesh_pkg::coord_t ej_src_x   [NN];
  wire mesh_pkg::coord_t ej_src_y   [NN];
  wire  [`DATA_W-1:0]    ej_data    [NN];
  logic [NN-1:0]         ej_ack;

  // packet table with one entry per stimulus line
  string              pkt_test  [$];
  int                 pkt_src   [$];
  int                 pkt_dx    [$];
  int                 pkt_dy    [$];
  logic [`DATA_W-1:0] pkt_data  [$];
  int                 pkt_delay [$];
  int                 pkt_node  [$];
  bit                 pkt_sent  [$];
  bit                 pkt_done  [$];
  string              test_name  [$];
  int                 test_first [$];
  int                 test_count [$];

  logic [31:0] lfsr_q;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          delivered;
  int          sent;
  int          cur_test;
  int          run_seq;
  bit          hosts_on;
  bit          loaded;

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mesh_array u_mesh_array (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .inj_req_i    (inj_req),
    .inj_dest_x_i (inj_dest_x),
    .inj_dest_y_i (inj_dest_y),
    .inj_data_i   (inj_data),
    .inj_ack_o    (inj_ack),
    .ej_req_o     (ej_req),
    .ej_src_x_o   (ej_src_x),
    .ej_src_y_o   (ej_src_y),
    .ej_data_o    (ej_data),
    .ej_ack_i     (ej_ack)
  );

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("error: test %s, %s: expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // one LFSR step per payload bit
  function automatic logic [`DATA_W-1:0] random_payload();
    logic [`DATA_W-1:0] bits;
    bits = '0;
    for (int b = 0; b < `DATA_W; b++)
    begin
      bits   = {bits[`DATA_W-2:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return bits;
  endfunction

  // source coordinates and payload in one word for comparison
  function automatic logic [31:0] delivery_word(input int sx, input int sy,
                                                input logic [`DATA_W-1:0] data);
    return (32'(sx) << (`COORD_W + `DATA_W)) | (32'(sy) << `DATA_W) | 32'(data);
  endfunction

  // oldest outstanding packet of one source/destination pair
  function automatic int find_pending(input int src, input int node);
    for (int i = 0; i < pkt_src.size(); i++)
    begin
      if (pkt_sent[i] && !pkt_done[i] && pkt_src[i] == src && pkt_node[i] == node)
        return i;
    end
    return -1;
  endfunction

  task automatic load_stimulus();
    int                 fd;
    int                 cnt;
    string              line;
    string              name;
    int                 src;
    int                 dx;
    int                 dy;
    int                 dly;
    int                 node;
    int unsigned        pl;
    logic [`DATA_W-1:0] data;
    lfsr_q = 32'h7b3e58ed;
    fd = $fopen("tests/mesh_stimulus.txt", "r");
    if (fd == 0)
    begin
      report_failure("could not open the stimulus file tests/mesh_stimulus.txt");
      return;
    end
    while (!$feof(fd))
    begin
      cnt = $fgets(line, fd);
      if (cnt == 0)
        break;
      cnt = $sscanf(line, "%s %d %d %d %h %d %d", name, src, dx, dy, pl, dly, node);
      // comment and blank lines do not parse to seven fields
      if (cnt != 7)
        continue;
      if (src >= NN || dx >= `MESH_X || dy >= `MESH_Y || node >= NN)
      begin
        report_failure($sformatf("stimulus line out of the grid: %s", line));
        continue;
      end
      data = (pl == 'hffff) ? random_payload() : pl[`DATA_W-1:0];
      if (test_name.size() == 0 || test_name[test_name.size()-1] != name)
      begin
        test_name.push_back(name);
        test_first.push_back(pkt_src.size());
        test_count.push_back(0);
      end
      test_count[test_count.size()-1]++;
      pkt_test.push_back(name);
      pkt_src.push_back(src);
      pkt_dx.push_back(dx);
      pkt_dy.push_back(dy);
      pkt_data.push_back(data);
      pkt_delay.push_back(dly);
      pkt_node.push_back(node);
      pkt_sent.push_back(1'b0);
      pkt_done.push_back(1'b0);
    end
    $fclose(fd);
  endtask

  task automatic send_packet(input int n, input int i);
    next_cycle();
    pkt_sent[i]   = 1'b1;
    inj_dest_x[n] = mesh_pkg::coord_t'(pkt_dx[i]);
    inj_dest_y[n] = mesh_pkg::coord_t'(pkt_dy[i]);
    inj_data[n]   = pkt_data[i];
    inj_req[n]    = 1'b1;
    while (!inj_ack[n])
      next_cycle();
    inj_req[n] = 1'b0;
    while (inj_ack[n])
      next_cycle();
    sent++;
  endtask

  task automatic inject_host(input int n);
    int seen;
    seen = 0;
    forever
    begin
      wait (run_seq != seen);
      seen = run_seq;
      for (int i = test_first[cur_test]; i < test_first[cur_test] + test_count[cur_test]; i++)
      begin
        if (pkt_src[i] == n)
          send_packet(n, i);
      end
    end
  endtask

  task automatic eject_host(input int n);
    int          src;
    int          idx;
    logic [31:0] got;
    wait (hosts_on);
    forever
    begin
      next_cycle();
      if (ej_req[n])
      begin
        src = int'(ej_src_y[n]) * `MESH_X + int'(ej_src_x[n]);
        got = delivery_word(ej_src_x[n], ej_src_y[n], ej_data[n]);
        idx = find_pending(src, n);
        if (idx < 0)
          report_failure($sformatf(
            "node %0d received a packet from node %0d that was not expected, payload %h",
            n, src, ej_data[n]));
        else
        begin
          pkt_done[idx] = 1'b1;
          check_value(pkt_test[idx], "delivery",
                      delivery_word(pkt_src[idx] % `MESH_X, pkt_src[idx] / `MESH_X, pkt_data[idx]),
                      got);
          // a slow host leaves the flit parked in the endpoint
          repeat (pkt_delay[idx])
          begin
            next_cycle();
            check_value(pkt_test[idx], "held eject data", got,
                        delivery_word(ej_src_x[n], ej_src_y[n], ej_data[n]));
          end
        end
        ej_ack[n] = 1'b1;
        while (ej_req[n])
          next_cycle();
        ej_ack[n] = 1'b0;
        // a delivery counts once its handshake is complete
        if (idx >= 0)
          delivered++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int pkts, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("test %-14s %3d packets  pass", name, pkts);
    else
    begin
      tests_failed++;
      $display("test %-14s %3d packets  FAIL, %0d errors", name, pkts, errors - err_before);
    end
  endtask

  task automatic run_test(input int t);
    int err_before;
    err_before = errors;
    delivered  = 0;
    sent       = 0;
    cur_test   = t;
    run_seq++;
    while (delivered < test_count[t] || sent < test_count[t])
      next_cycle();
    // a duplicate would show up as a late eject request
    repeat (10) next_cycle();
    check_value(test_name[t], "eject requests after drain", '0, ej_req);
    finish_test(test_name[t], test_count[t], err_before);
  endtask

  for (genvar n = 0; n < NN; n++)
  begin : g_host
    initial inject_host(n);
    initial eject_host(n);
  end

  initial
  begin
    int err_before;
    inj_req = '0;
    ej_ack  = '0;
    for (int n = 0; n < NN; n++)
    begin
      inj_dest_x[n] = '0;
      inj_dest_y[n] = '0;
      inj_data[n]   = '0;
    end
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_stimulus();
    loaded = 1'b1;
    wait (rst_n === 1'b1);
    // handshake outputs stay low through the reset pipeline and after it
    err_before = errors;
    for (int c = 0; c < `RESET_DEPTH + 5; c++)
    begin
      next_cycle();
      check_value("reset_idle", "ack and request outputs", '0, {ej_req, inj_ack});
    end
    finish_test("reset_idle", 0, err_before);
    hosts_on = 1'b1;
    for (int t = 0; t < test_name.size(); t++)
      run_test(t);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // budget of 200 cycles per packet plus the reset and idle checks
  initial
  begin
    wait (loaded);
    repeat (pkt_src.size() * 200 + 100) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", pkt_src.size() * 200 + 100);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/mesh_stimulus.txt ====
# test src_node dest_x dest_y payload(hex, ffff = LFSR) eject_ack_delay expected_eject_node
# nodes are y*2+x: 0=(0,0) 1=(1,0) 2=(0,1) 3=(1,1)
east_hop     0 1 0 a001 0 1
west_hop     1 0 0 a002 0 0
north_hop    0 0 1 a003 2 2
south_hop    3 1 0 a004 0 1
diagonal     0 1 1 a005 0 3
diagonal     3 0 0 a006 1 0
self_loop    2 0 1 b007 0 2
self_loop    1 1 0 b008 0 1
in_order     0 1 1 c001 0 3
in_order     0 1 1 c002 0 3
in_order     0 1 1 c003 3 3
in_order     0 1 1 c004 0 3
backpressure 0 1 1 d001 40 3
backpressure 1 1 1 d002 40 3
backpressure 2 1 1 d003 40 3
backpressure 0 0 1 d004 0 2
backpressure 1 0 0 d005 0 0
backpressure 0 1 1 d006 40 3
all_to_one   0 0 1 ffff 0 2
all_to_one   1 0 1 ffff 0 2
all_to_one   2 0 1 ffff 0 2
all_to_one   3 0 1 ffff 0 2
all_to_one   0 0 1 ffff 0 2
all_to_one   1 0 1 ffff 0 2

// ==== compile.f ====
+incdir+src
src/mesh_pkg.sv
src/reset_pipe.sv
src/rr_arbiter.sv
src/mesh_router.sv
src/endpoint_fsm.sv
src/mesh_array.sv
tests/tb_clock.sv
tests/mesh_tb.sv
